// File: hw/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit (
    input  logic                  clk,
    input  logic                  rst,

    output logic                  imem_req_valid,
    input  logic                  imem_req_ready,
    output rename_pkg::xlen_t     imem_addr,
    input  logic                  imem_resp_valid,
    input  rename_pkg::xlen_t     imem_resp_data,

    output logic                  fq_valid,
    input  logic                  fq_ready,
    output rename_pkg::xlen_t     fq_pc,
    output rename_pkg::arch_reg_t fq_rs1,
    output rename_pkg::arch_reg_t fq_rs2,
    output rename_pkg::arch_reg_t fq_rd,
    output logic                  fq_has_rd
);

    typedef enum logic [1:0] {
        ST_REQ,
        ST_WAIT,
        ST_HOLD
    } fetch_state_t;

    fetch_state_t          state;
    fetch_state_t          state_next;
    rename_pkg::xlen_t     pc;
    rename_pkg::opcode_t   resp_opcode;
    rename_pkg::arch_reg_t resp_rd;
    logic                  resp_has_rd;
    logic                  req_fire;
    logic                  resp_fire;

    assign imem_req_valid = (state == ST_REQ);
    assign imem_addr      = pc;
    assign req_fire       = imem_req_valid && imem_req_ready;
    assign resp_fire      = (state == ST_WAIT) && imem_resp_valid;

    // Field extraction from the returned word
    assign resp_opcode = imem_resp_data[6:0];
    assign resp_rd     = imem_resp_data[11:7];
    assign resp_has_rd = (resp_opcode != rename_pkg::OPC_STORE) &&
                         (resp_opcode != rename_pkg::OPC_BRANCH) &&
                         (resp_rd != '0);

    always_comb begin
        state_next = state;
        case (state)
            ST_REQ: begin
                if (imem_req_ready) begin
                    state_next = ST_WAIT;
                end
            end
            ST_WAIT: begin
                if (imem_resp_valid) begin
                    state_next = ST_HOLD;
                end
            end
            // Leave once the held entry is gone or being taken
            ST_HOLD: begin
                if (!fq_valid || fq_ready) begin
                    state_next = ST_REQ;
                end
            end
            default: begin
                state_next = ST_HOLD;
            end
        endcase
    end

    // Reset parks in HOLD with no entry, so the first request starts a cycle later
    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= ST_HOLD;
            pc       <= rename_pkg::RESET_PC;
            fq_valid <= 1'b0;
        end else begin
            state <= state_next;
            if (req_fire) begin
                pc <= pc + 32'd4;
            end
            if (resp_fire) begin
                fq_valid <= 1'b1;
            end else if (fq_valid && fq_ready) begin
                fq_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        // PC of the request in flight is loaded only while no entry is held
        if (req_fire) begin
            fq_pc <= pc;
        end
        if (resp_fire) begin
            fq_rs1    <= imem_resp_data[19:15];
            fq_rs2    <= imem_resp_data[24:20];
            fq_rd     <= resp_rd;
            fq_has_rd <= resp_has_rd;
        end
    end

endmodule

// File: hw/free_list.sv
`timescale 1ns/1ps

module free_list #(
    parameter int PR_ENTRIES = 64,
    parameter int PREG_W     = 6
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              push,
    input  logic [PREG_W-1:0] push_preg,
    input  logic              pop,
    output logic [PREG_W-1:0] head_preg,
    output logic              empty
);

    // Registers above the architectural set start out free
    localparam int CAP   = PR_ENTRIES - rename_pkg::ARCH_REGS;
    localparam int IDX_W = $clog2(CAP);
    localparam int CNT_W = $clog2(CAP + 1);

    logic [PREG_W-1:0] list_mem [CAP];
    logic [IDX_W-1:0]  head;
    logic [IDX_W-1:0]  tail;
    logic [CNT_W-1:0]  count;

    assign empty     = (count == '0);
    assign head_preg = list_mem[head];

    // Capacity need not be a power of two, so wrap explicitly
    function automatic logic [IDX_W-1:0] next_idx(input logic [IDX_W-1:0] idx);
        next_idx = (idx == IDX_W'(CAP - 1)) ? '0 : idx + 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            head  <= '0;
            tail  <= '0;
            count <= CNT_W'(CAP);
            for (int i = 0; i < CAP; i++) begin
                list_mem[i] <= PREG_W'(rename_pkg::ARCH_REGS + i);
            end
        end else begin
            if (push) begin
                list_mem[tail] <= push_preg;
                tail           <= next_idx(tail);
            end
            if (pop) begin
                head <= next_idx(head);
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// File: hw/inst_queue.sv
`timescale 1ns/1ps

module inst_queue #(
    parameter int IQ_DEPTH = 8
) (
    input  logic                  clk,
    input  logic                  rst,

    input  logic                  push_valid,
    output logic                  push_ready,
    input  rename_pkg::xlen_t     push_pc,
    input  rename_pkg::arch_reg_t push_rs1,
    input  rename_pkg::arch_reg_t push_rs2,
    input  rename_pkg::arch_reg_t push_rd,
    input  logic                  push_has_rd,

    output logic                  pop_valid,
    input  logic                  pop_ready,
    output rename_pkg::xlen_t     pop_pc,
    output rename_pkg::arch_reg_t pop_rs1,
    output rename_pkg::arch_reg_t pop_rs2,
    output rename_pkg::arch_reg_t pop_rd,
    output logic                  pop_has_rd
);

    localparam int PTR_W = $clog2(IQ_DEPTH);

    rename_pkg::xlen_t     pc_mem     [IQ_DEPTH];
    rename_pkg::arch_reg_t rs1_mem    [IQ_DEPTH];
    rename_pkg::arch_reg_t rs2_mem    [IQ_DEPTH];
    rename_pkg::arch_reg_t rd_mem     [IQ_DEPTH];
    logic                  has_rd_mem [IQ_DEPTH];

    // Top bit of each pointer is the wrap bit
    logic [PTR_W:0] head;
    logic [PTR_W:0] tail;
    logic           full;
    logic           empty;
    logic           do_push;
    logic           do_pop;

    assign empty = (head == tail);
    assign full  = (head[PTR_W] != tail[PTR_W]) &&
                   (head[PTR_W-1:0] == tail[PTR_W-1:0]);

    assign push_ready = !full;
    assign pop_valid  = !empty;
    assign do_push    = push_valid && push_ready;
    assign do_pop     = pop_valid && pop_ready;

    assign pop_pc     = pc_mem[head[PTR_W-1:0]];
    assign pop_rs1    = rs1_mem[head[PTR_W-1:0]];
    assign pop_rs2    = rs2_mem[head[PTR_W-1:0]];
    assign pop_rd     = rd_mem[head[PTR_W-1:0]];
    assign pop_has_rd = has_rd_mem[head[PTR_W-1:0]];

    always_ff @(posedge clk) begin
        if (rst) begin
            head <= '0;
            tail <= '0;
        end else begin
            if (do_push) begin
                tail <= tail + 1'b1;
            end
            if (do_pop) begin
                head <= head + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            pc_mem[tail[PTR_W-1:0]]     <= push_pc;
            rs1_mem[tail[PTR_W-1:0]]    <= push_rs1;
            rs2_mem[tail[PTR_W-1:0]]    <= push_rs2;
            rd_mem[tail[PTR_W-1:0]]     <= push_rd;
            has_rd_mem[tail[PTR_W-1:0]] <= push_has_rd;
        end
    end

endmodule

// File: hw/rename_frontend.sv
`timescale 1ns/1ps

module rename_frontend #(
    parameter int PR_ENTRIES = 64,
    parameter int IQ_DEPTH   = 8,
    localparam int PREG_W    = $clog2(PR_ENTRIES)
) (
    input  logic              clk,
    input  logic              rst,

    output logic              imem_req_valid,
    input  logic              imem_req_ready,
    output rename_pkg::xlen_t imem_addr,
    input  logic              imem_resp_valid,
    input  rename_pkg::xlen_t imem_resp_data,

    input  logic              retire_valid,
    input  logic [PREG_W-1:0] retire_preg,

    output logic              rn_valid,
    input  logic              rn_ready,
    output rename_pkg::xlen_t rn_pc,
    output logic [PREG_W-1:0] rn_pr_rs1,
    output logic [PREG_W-1:0] rn_pr_rs2,
    output logic [PREG_W-1:0] rn_pr_rd,
    output logic [PREG_W-1:0] rn_old_pr_rd,
    output logic              rn_has_rd
);

    // Fetch to queue
    logic                  fq_valid;
    logic                  fq_ready;
    rename_pkg::xlen_t     fq_pc;
    rename_pkg::arch_reg_t fq_rs1;
    rename_pkg::arch_reg_t fq_rs2;
    rename_pkg::arch_reg_t fq_rd;
    logic                  fq_has_rd;

    // Queue to rename
    logic                  iq_valid;
    logic                  iq_ready;
    rename_pkg::xlen_t     iq_pc;
    rename_pkg::arch_reg_t iq_rs1;
    rename_pkg::arch_reg_t iq_rs2;
    rename_pkg::arch_reg_t iq_rd;
    logic                  iq_has_rd;

    fetch_unit i_fetch_unit (
        .clk             (clk),
        .rst             (rst),
        .imem_req_valid  (imem_req_valid),
        .imem_req_ready  (imem_req_ready),
        .imem_addr       (imem_addr),
        .imem_resp_valid (imem_resp_valid),
        .imem_resp_data  (imem_resp_data),
        .fq_valid        (fq_valid),
        .fq_ready        (fq_ready),
        .fq_pc           (fq_pc),
        .fq_rs1          (fq_rs1),
        .fq_rs2          (fq_rs2),
        .fq_rd           (fq_rd),
        .fq_has_rd       (fq_has_rd)
    );

    inst_queue #(
        .IQ_DEPTH (IQ_DEPTH)
    ) i_inst_queue (
        .clk         (clk),
        .rst         (rst),
        .push_valid  (fq_valid),
        .push_ready  (fq_ready),
        .push_pc     (fq_pc),
        .push_rs1    (fq_rs1),
        .push_rs2    (fq_rs2),
        .push_rd     (fq_rd),
        .push_has_rd (fq_has_rd),
        .pop_valid   (iq_valid),
        .pop_ready   (iq_ready),
        .pop_pc      (iq_pc),
        .pop_rs1     (iq_rs1),
        .pop_rs2     (iq_rs2),
        .pop_rd      (iq_rd),
        .pop_has_rd  (iq_has_rd)
    );

    rename_unit #(
        .PR_ENTRIES (PR_ENTRIES),
        .PREG_W     (PREG_W)
    ) i_rename_unit (
        .clk          (clk),
        .rst          (rst),
        .iq_valid     (iq_valid),
        .iq_ready     (iq_ready),
        .iq_pc        (iq_pc),
        .iq_rs1       (iq_rs1),
        .iq_rs2       (iq_rs2),
        .iq_rd        (iq_rd),
        .iq_has_rd    (iq_has_rd),
        .retire_valid (retire_valid),
        .retire_preg  (retire_preg),
        .rn_valid     (rn_valid),
        .rn_ready     (rn_ready),
        .rn_pc        (rn_pc),
        .rn_pr_rs1    (rn_pr_rs1),
        .rn_pr_rs2    (rn_pr_rs2),
        .rn_pr_rd     (rn_pr_rd),
        .rn_old_pr_rd (rn_old_pr_rd),
        .rn_has_rd    (rn_has_rd)
    );

endmodule

// File: hw/rename_pkg.sv
package rename_pkg;

    // Machine word for PCs and instruction bits
    typedef logic [31:0] xlen_t;

    // Architectural register index
    typedef logic [4:0] arch_reg_t;

    // Major opcode field of an RV32 instruction
    typedef logic [6:0] opcode_t;

    // Size of the architectural register file
    localparam int ARCH_REGS = 32;

    // First fetch address out of reset
    localparam xlen_t RESET_PC = 32'h0000_0000;

    // Opcodes whose rd field is not a destination
    localparam opcode_t OPC_STORE  = 7'b0100011;
    localparam opcode_t OPC_BRANCH = 7'b1100011;

endpackage

// File: hw/rename_unit.sv
`timescale 1ns/1ps

module rename_unit #(
    parameter int PR_ENTRIES = 64,
    parameter int PREG_W     = 6
) (
    input  logic                  clk,
    input  logic                  rst,

    input  logic                  iq_valid,
    output logic                  iq_ready,
    input  rename_pkg::xlen_t     iq_pc,
    input  rename_pkg::arch_reg_t iq_rs1,
    input  rename_pkg::arch_reg_t iq_rs2,
    input  rename_pkg::arch_reg_t iq_rd,
    input  logic                  iq_has_rd,

    input  logic                  retire_valid,
    input  logic [PREG_W-1:0]     retire_preg,

    output logic                  rn_valid,
    input  logic                  rn_ready,
    output rename_pkg::xlen_t     rn_pc,
    output logic [PREG_W-1:0]     rn_pr_rs1,
    output logic [PREG_W-1:0]     rn_pr_rs2,
    output logic [PREG_W-1:0]     rn_pr_rd,
    output logic [PREG_W-1:0]     rn_old_pr_rd,
    output logic                  rn_has_rd
);

    // Current architectural to physical mapping
    logic [PREG_W-1:0] rat [rename_pkg::ARCH_REGS];

    logic [PREG_W-1:0] fl_head;
    logic              fl_empty;
    logic              out_free;
    logic              do_pop;

    // Output slot empty now or emptied this cycle
    assign out_free = !rn_valid || rn_ready;
    assign iq_ready = out_free && (!iq_has_rd || !fl_empty);
    assign do_pop   = iq_valid && iq_ready;

    free_list #(
        .PR_ENTRIES (PR_ENTRIES),
        .PREG_W     (PREG_W)
    ) i_free_list (
        .clk       (clk),
        .rst       (rst),
        .push      (retire_valid),
        .push_preg (retire_preg),
        .pop       (do_pop && iq_has_rd),
        .head_preg (fl_head),
        .empty     (fl_empty)
    );

    // Sources read the table before this instruction's own write lands
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < rename_pkg::ARCH_REGS; i++) begin
                rat[i] <= PREG_W'(i);
            end
        end else if (do_pop && iq_has_rd) begin
            rat[iq_rd] <= fl_head;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rn_valid <= 1'b0;
        end else if (do_pop) begin
            rn_valid <= 1'b1;
        end else if (rn_ready) begin
            rn_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (do_pop) begin
            rn_pc        <= iq_pc;
            rn_pr_rs1    <= rat[iq_rs1];
            rn_pr_rs2    <= rat[iq_rs2];
            rn_pr_rd     <= iq_has_rd ? fl_head : '0;
            rn_old_pr_rd <= iq_has_rd ? rat[iq_rd] : '0;
            rn_has_rd    <= iq_has_rd;
        end
    end

endmodule

// File: run.sh
#!/bin/sh
# Build and run the rename front end testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f src.f \
    --top-module tb_rename_frontend -o tb_sim
./obj_dir/tb_sim > sim.log 2>&1 || true
cat sim.log
grep -q "Everything OK" sim.log

// File: src.f
+incdir+verification
hw/rename_pkg.sv
hw/fetch_unit.sv
hw/inst_queue.sv
hw/free_list.sv
hw/rename_unit.sv
hw/rename_frontend.sv
verification/tb_rename_frontend.sv

// File: verification/tb_rename_checks.svh
`ifndef TB_RENAME_CHECKS_SVH
`define TB_RENAME_CHECKS_SVH

// Reference RAT and free list advanced on every rn transfer and retire push
int                ref_rat [rename_pkg::ARCH_REGS];
int                free_q [$];
int                retire_q [$];
rename_pkg::xlen_t exp_pc;

int errors;
int checks;
int rn_count;
int writer_count;
int plain_count;
int dep_hits;
int recycled;

// Output fields captured while rn_ready is low
rename_pkg::xlen_t held_pc;
logic [PREG_W-1:0] held_rs1;
logic [PREG_W-1:0] held_rs2;
logic [PREG_W-1:0] held_rd;
logic [PREG_W-1:0] held_old;
logic              held_has_rd;

task automatic init_model();
    free_q.delete();
    retire_q.delete();
    for (int i = 0; i < rename_pkg::ARCH_REGS; i++) begin
        ref_rat[i] = i;
    end
    for (int i = rename_pkg::ARCH_REGS; i < PR_ENTRIES; i++) begin
        free_q.push_back(i);
    end
    exp_pc = rename_pkg::RESET_PC;
endtask

// Stores and branches reuse bits 11:7 as immediate
function automatic bit writes_reg(input rename_pkg::xlen_t word);
    if (word[6:0] == rename_pkg::OPC_STORE || word[6:0] == rename_pkg::OPC_BRANCH) begin
        return 1'b0;
    end
    return word[11:7] != 5'd0;
endfunction

task automatic report_mismatch(input string name, input longint exp, input longint act);
    $display("[FAIL] t=%0t %s expected 0x%0h got 0x%0h", $time, name, exp, act);
    errors++;
endtask

task automatic note_failure(input string what);
    $display("Error at t=%0t: %s", $time, what);
    errors++;
endtask

task automatic expect_eq(input string name, input longint exp, input longint act);
    checks++;
    assert (exp == act) else report_mismatch(name, exp, act);
endtask

task automatic check_transfer();
    rename_pkg::xlen_t word;
    int                rs1;
    int                rs2;
    int                rd;
    int                new_preg;
    word = prog[exp_pc[9:2]];
    rs1  = word[19:15];
    rs2  = word[24:20];
    rd   = word[11:7];
    expect_eq("rn_pc", exp_pc, rn_pc);
    expect_eq("rn_pr_rs1", ref_rat[rs1], rn_pr_rs1);
    expect_eq("rn_pr_rs2", ref_rat[rs2], rn_pr_rs2);
    expect_eq("rn_has_rd", writes_reg(word), rn_has_rd);
    if (ref_rat[rs1] != rs1 || ref_rat[rs2] != rs2) begin
        dep_hits++;
    end
    if (writes_reg(word)) begin
        assert (free_q.size() > 0) else note_failure("destination renamed with no free register");
        if (free_q.size() > 0) begin
            new_preg = free_q.pop_front();
            expect_eq("rn_pr_rd", new_preg, rn_pr_rd);
            expect_eq("rn_old_pr_rd", ref_rat[rd], rn_old_pr_rd);
            // Past the initial free set every index is a recycled one
            if (writer_count >= PR_ENTRIES - rename_pkg::ARCH_REGS) begin
                recycled++;
            end
            retire_q.push_back(ref_rat[rd]);
            ref_rat[rd] = new_preg;
        end
        writer_count++;
    end else begin
        expect_eq("rn_pr_rd", 0, rn_pr_rd);
        expect_eq("rn_old_pr_rd", 0, rn_old_pr_rd);
        plain_count++;
    end
    exp_pc = exp_pc + 32'd4;
    rn_count++;
endtask

task automatic save_held();
    held_pc     = rn_pc;
    held_rs1    = rn_pr_rs1;
    held_rs2    = rn_pr_rs2;
    held_rd     = rn_pr_rd;
    held_old    = rn_old_pr_rd;
    held_has_rd = rn_has_rd;
endtask

task automatic check_held();
    expect_eq("rn_valid", 1, rn_valid);
    expect_eq("rn_pc", held_pc, rn_pc);
    expect_eq("rn_pr_rs1", held_rs1, rn_pr_rs1);
    expect_eq("rn_pr_rs2", held_rs2, rn_pr_rs2);
    expect_eq("rn_pr_rd", held_rd, rn_pr_rd);
    expect_eq("rn_old_pr_rd", held_old, rn_old_pr_rd);
    expect_eq("rn_has_rd", held_has_rd, rn_has_rd);
endtask

`endif

// File: verification/tb_rename_frontend.sv
`timescale 1ns/1ps

module tb_rename_frontend;

    localparam int PR_ENTRIES = 64;
    localparam int IQ_DEPTH   = 8;
    localparam int PREG_W     = $clog2(PR_ENTRIES);

    logic              clk;
    logic              rst;
    logic              imem_req_valid;
    logic              imem_req_ready;
    rename_pkg::xlen_t imem_addr;
    logic              imem_resp_valid;
    rename_pkg::xlen_t imem_resp_data;
    logic              retire_valid;
    logic [PREG_W-1:0] retire_preg;
    logic              rn_valid;
    logic              rn_ready;
    rename_pkg::xlen_t rn_pc;
    logic [PREG_W-1:0] rn_pr_rs1;
    logic [PREG_W-1:0] rn_pr_rs2;
    logic [PREG_W-1:0] rn_pr_rd;
    logic [PREG_W-1:0] rn_old_pr_rd;
    logic              rn_has_rd;

    // Program image indexed by pc[9:2]
    rename_pkg::xlen_t prog [256];

    // 0 random, 1 always ready, 2 held low
    int                ready_mode;
    bit                retire_en;
    bit                pending;
    int                resp_delay;
    rename_pkg::xlen_t pend_addr;
    int                req_count;
    bit                stalled;
    int                tests_run;
    int                tests_failed;
    int                test_err_base;
    int                mark;

    `include "tb_rename_checks.svh"

    rename_frontend #(
        .PR_ENTRIES (PR_ENTRIES),
        .IQ_DEPTH   (IQ_DEPTH)
    ) i_rename_frontend (
        .clk             (clk),
        .rst             (rst),
        .imem_req_valid  (imem_req_valid),
        .imem_req_ready  (imem_req_ready),
        .imem_addr       (imem_addr),
        .imem_resp_valid (imem_resp_valid),
        .imem_resp_data  (imem_resp_data),
        .retire_valid    (retire_valid),
        .retire_preg     (retire_preg),
        .rn_valid        (rn_valid),
        .rn_ready        (rn_ready),
        .rn_pc           (rn_pc),
        .rn_pr_rs1       (rn_pr_rs1),
        .rn_pr_rs2       (rn_pr_rs2),
        .rn_pr_rd        (rn_pr_rd),
        .rn_old_pr_rd    (rn_old_pr_rd),
        .rn_has_rd       (rn_has_rd)
    );

    always #50 clk = ~clk;

    // Mostly ALU ops on x0..x7 with stores, branches and rd=0 mixed in
    function automatic rename_pkg::xlen_t make_word();
        int                    kind;
        rename_pkg::arch_reg_t rs1;
        rename_pkg::arch_reg_t rs2;
        rename_pkg::arch_reg_t rd;
        rename_pkg::opcode_t   opc;
        kind = $urandom % 10;
        rs1  = 5'($urandom % 8);
        rs2  = 5'($urandom % 8);
        rd   = 5'(1 + $urandom % 7);
        opc  = 7'b0110011;
        if (kind == 0) begin
            opc = rename_pkg::OPC_STORE;
        end else if (kind == 1) begin
            opc = rename_pkg::OPC_BRANCH;
        end else if (kind == 2) begin
            rd = 5'd0;
        end
        return {7'b0, rs2, rs1, 3'b000, rd, opc};
    endfunction

    // Memory, rn_ready and retire drivers
    always @(negedge clk) begin
        if (!rst) begin
            if (stalled) begin
                check_held();
            end
            imem_resp_valid = 1'b0;
            if (pending) begin
                imem_req_ready = 1'b0;
                if (resp_delay == 0) begin
                    imem_resp_valid = 1'b1;
                    imem_resp_data  = prog[pend_addr[9:2]];
                    pending         = 1'b0;
                end else begin
                    resp_delay--;
                end
            end else begin
                imem_req_ready = ($urandom % 4) != 0;
                if (imem_req_valid && imem_req_ready) begin
                    // Fetch is strictly sequential from the reset PC
                    expect_eq("imem_addr", rename_pkg::RESET_PC + 32'(req_count * 4),
                              imem_addr);
                    pending    = 1'b1;
                    pend_addr  = imem_addr;
                    resp_delay = $urandom % 3;
                    req_count++;
                end
            end
            case (ready_mode)
                0: rn_ready = ($urandom % 3) != 0;
                1: rn_ready = 1'b1;
                default: rn_ready = 1'b0;
            endcase
            if (rn_valid && rn_ready) begin
                check_transfer();
            end
            stalled = rn_valid && !rn_ready;
            if (stalled) begin
                save_held();
            end
            retire_valid = 1'b0;
            if (retire_en && retire_q.size() > 0 && ($urandom % 2) == 0) begin
                retire_valid = 1'b1;
                retire_preg  = PREG_W'(retire_q.pop_front());
                free_q.push_back(retire_preg);
            end
        end
    end

    task automatic wait_renames(input int n, input int limit);
        int target;
        int cycles;
        target = rn_count + n;
        cycles = 0;
        while (rn_count < target && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (rn_count < target) begin
            note_failure($sformatf("%0d renamed instructions not seen within %0d cycles",
                                   n, limit));
        end
    endtask

    task automatic wait_free_empty(input int limit);
        int cycles;
        cycles = 0;
        while (free_q.size() > 0 && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (free_q.size() > 0) begin
            note_failure($sformatf("free list never ran out within %0d cycles", limit));
        end
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors != test_err_base) begin
            tests_failed++;
        end
        $display("Test %0d %s: %s, %0d errors", tests_run, name,
                 (errors == test_err_base) ? "passed" : "failed", errors - test_err_base);
        test_err_base = errors;
    endtask

    initial begin
        void'($urandom(46));
        clk             = 1'b0;
        rst             = 1'b1;
        imem_req_ready  = 1'b0;
        imem_resp_valid = 1'b0;
        imem_resp_data  = '0;
        retire_valid    = 1'b0;
        retire_preg     = '0;
        rn_ready        = 1'b0;
        ready_mode      = 0;
        retire_en       = 1'b0;
        pending         = 1'b0;
        stalled         = 1'b0;
        for (int i = 0; i < 256; i++) begin
            prog[i] = make_word();
        end
        init_model();
        repeat (16) @(negedge clk);

        expect_eq("imem_req_valid", 0, imem_req_valid);
        expect_eq("rn_valid", 0, rn_valid);
        rst = 1'b0;
        wait_renames(1, 200);
        end_test("reset state and identity mapping");

        wait_renames(12, 2000);
        end_test("sequential pc under random back-pressure");

        wait_renames(8, 2000);
        assert (writer_count > 0) else note_failure("no destination was allocated");
        assert (dep_hits > 0) else note_failure("no source read a renamed register");
        end_test("destination allocation and old mapping");

        wait_renames(4, 1000);
        assert (plain_count > 0) else note_failure("no instruction without destination seen");
        end_test("instructions without destination");

        // Exhaust the free list, then let retire refill it
        ready_mode = 1;
        wait_free_empty(4000);
        repeat (30) @(negedge clk);
        expect_eq("rn_valid", 0, rn_valid);
        mark      = recycled;
        retire_en = 1'b1;
        wait_renames(24, 3000);
        assert (recycled > mark) else note_failure("no recycled register was reallocated");
        end_test("free list exhaustion and recycling");

        ready_mode = 2;
        mark       = req_count;
        repeat (150) @(negedge clk);
        expect_eq("imem_req_valid", 0, imem_req_valid);
        expect_eq("rn_valid", 1, rn_valid);
        assert (req_count - mark <= IQ_DEPTH + 3) else note_failure("fetch ran past a full queue");
        ready_mode = 0;
        wait_renames(IQ_DEPTH + 4, 2000);
        end_test("stall with rn_ready low");

        $display("Tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule
